// File: verilog/vstream_pkg.sv
package vstream_pkg;

    // Number of columns in the processing array.
    localparam int NUM_COL = 4;

    // Maximum number of result elements held by one column.
    localparam int VEC_LEN = 4;

    // Width of an element index.
    // A stored stream length is kept as length minus one, so it fits the same width.
    localparam int IDX_W = $clog2(VEC_LEN);

    // Width of one result word.
    localparam int DATA_W = 16;

    // Result register file geometry.
    localparam int RF_DEPTH = 32;
    localparam int RF_ADDR_W = $clog2(RF_DEPTH);

endpackage

// File: verilog/vstream_config.sv
`timescale 1ns/1ps

module vstream_config
    import vstream_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cfg_we,
    input  logic [1:0]                       cfg_col,
    input  logic [IDX_W-1:0]                 cfg_len_m1,
    output logic [NUM_COL-1:0][IDX_W-1:0]    len_m1
);

    // One stored length per column, kept as the element count minus one.
    // After reset every column streams its full buffer.
    logic [NUM_COL-1:0][IDX_W-1:0] len_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_COL; c++) begin
                len_q[c] <= IDX_W'(VEC_LEN - 1);
            end
        end else if (cfg_we) begin
            len_q[cfg_col] <= cfg_len_m1;
        end
    end

    // The columns sample their length directly from the register outputs.
    assign len_m1 = len_q;

endmodule

// File: verilog/vstream_column.sv
`timescale 1ns/1ps

module vstream_column
    import vstream_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              load_we,
    input  logic [IDX_W-1:0]  load_idx,
    input  logic [DATA_W-1:0] load_data,
    input  logic [IDX_W-1:0]  len_m1,
    input  logic              sel,
    output logic [DATA_W-1:0] data,
    output logic              valid,
    output logic              done
);

    // Result buffer of this column.
    logic [DATA_W-1:0] buffer [VEC_LEN];

    // Index of the element presented while the column is selected.
    logic [IDX_W-1:0] idx;

    logic last_elem;

    // Results are loaded directly, one entry per write.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                buffer[i] <= '0;
            end
        end else if (load_we) begin
            buffer[load_idx] <= load_data;
        end
    end

    assign last_elem = (idx == len_m1);

    // The index only moves while the column supplies data.
    // It wraps to zero on the last element, so the next stream starts clean.
    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (sel) begin
            if (last_elem) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // The element goes out in the same cycle as the select bit.
    assign data  = buffer[idx];
    assign valid = sel;
    assign done  = sel && last_elem;

endmodule

// File: verilog/vstreamout_control.sv
`timescale 1ns/1ps

module vstreamout_control
    import vstream_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_COL-1:0]   is_vstreamout,
    input  logic [NUM_COL-1:0]   done,
    input  logic [RF_ADDR_W-1:0] rd_addr,
    output logic [NUM_COL-1:0]   supplier,
    output logic [RF_ADDR_W-1:0] streamout_addr,
    output logic                 is_vstreamout_global,
    output logic [NUM_COL-1:0]   sel_mux2
);

    // Two-state FSM: low is idle, high is streaming.
    logic active;
    logic next_active;

    logic [NUM_COL-1:0] curr_supplier;
    logic [NUM_COL-1:0] next_supplier;
    logic [NUM_COL-1:0] curr_sel_mux2;
    logic [NUM_COL-1:0] next_sel_mux2;

    logic start;
    logic step;
    logic finish;

    // A request is only taken while idle; requests during a stream are dropped.
    assign start  = !active && (|is_vstreamout);

    // The supplying column hands over on its done.
    assign step   = active && (|(curr_supplier & done));

    // Done of the last column ends the stream.
    assign finish = active && curr_supplier[NUM_COL-1] && done[NUM_COL-1];

    always_comb begin
        next_active   = active;
        next_supplier = curr_supplier;
        next_sel_mux2 = curr_sel_mux2;
        if (start) begin
            next_active   = 1'b1;
            next_supplier = NUM_COL'(1);
            next_sel_mux2 = NUM_COL'(1);
        end else if (finish) begin
            next_active   = 1'b0;
            next_supplier = NUM_COL'(1);
            next_sel_mux2 = '0;
        end else if (step) begin
            next_supplier = curr_supplier << 1;
            next_sel_mux2 = curr_sel_mux2 << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active        <= 1'b0;
            curr_supplier <= NUM_COL'(1);
            curr_sel_mux2 <= '0;
        end else begin
            active        <= next_active;
            curr_supplier <= next_supplier;
            curr_sel_mux2 <= next_sel_mux2;
        end
    end

    // The start address is held for the whole stream, so later changes
    // on rd_addr do not move the writes.
    always_ff @(posedge clk) begin
        if (rst) begin
            streamout_addr <= '0;
        end else if (start) begin
            streamout_addr <= rd_addr;
        end
    end

    assign supplier             = curr_supplier;
    assign sel_mux2             = curr_sel_mux2;
    assign is_vstreamout_global = active;

endmodule

// File: verilog/vstream_regfile.sv
`timescale 1ns/1ps

module vstream_regfile
    import vstream_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [NUM_COL-1:0][DATA_W-1:0] col_data,
    input  logic [NUM_COL-1:0]             col_valid,
    input  logic [NUM_COL-1:0]             sel_mux2,
    input  logic [RF_ADDR_W-1:0]           streamout_addr,
    input  logic                           busy,
    input  logic [RF_ADDR_W-1:0]           rf_rd_addr,
    output logic [DATA_W-1:0]              rf_rd_data,
    output logic                           out_valid,
    output logic [DATA_W-1:0]              out_data
);

    logic [DATA_W-1:0] regs [RF_DEPTH];

    // Offset of the next word from the captured start address.
    logic [RF_ADDR_W-1:0] wr_offset;
    logic [RF_ADDR_W-1:0] wr_addr;

    // AND-OR mux on the one-hot select; at most one column is selected.
    always_comb begin
        out_data = '0;
        for (int c = 0; c < NUM_COL; c++) begin
            out_data = out_data | (col_data[c] & {DATA_W{sel_mux2[c]}});
        end
    end

    assign out_valid = |(sel_mux2 & col_valid);

    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            wr_offset <= '0;
        end else if (out_valid) begin
            wr_offset <= wr_offset + 1'b1;
        end
    end

    // Addition wraps modulo RF_DEPTH.
    assign wr_addr = streamout_addr + wr_offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (out_valid) begin
            regs[wr_addr] <= out_data;
        end
    end

    assign rf_rd_data = regs[rf_rd_addr];

endmodule

// File: verilog/vstream_unit.sv
`timescale 1ns/1ps

module vstream_unit
    import vstream_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // Direct load of column result buffers.
    input  logic                 load_we,
    input  logic [1:0]           load_col,
    input  logic [IDX_W-1:0]     load_idx,
    input  logic [DATA_W-1:0]    load_data,

    // Per-column stream length, written as length minus one.
    input  logic                 cfg_we,
    input  logic [1:0]           cfg_col,
    input  logic [IDX_W-1:0]     cfg_len_m1,

    // Stream-out request and its start address.
    input  logic [NUM_COL-1:0]   is_vstreamout,
    input  logic [RF_ADDR_W-1:0] rd_addr,

    // Result read-back.
    input  logic [RF_ADDR_W-1:0] rf_rd_addr,

    output logic                 busy,
    output logic [NUM_COL-1:0]   supplier,
    output logic                 out_valid,
    output logic [DATA_W-1:0]    out_data,
    output logic [DATA_W-1:0]    rf_rd_data
);

    logic [NUM_COL-1:0][IDX_W-1:0]  len_m1;
    logic [NUM_COL-1:0][DATA_W-1:0] col_data;
    logic [NUM_COL-1:0]             col_valid;
    logic [NUM_COL-1:0]             col_done;
    logic [NUM_COL-1:0]             col_load_we;
    logic [NUM_COL-1:0]             sel_mux2;
    logic [RF_ADDR_W-1:0]           streamout_addr;

    vstream_config u_config (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_col    (cfg_col),
        .cfg_len_m1 (cfg_len_m1),
        .len_m1     (len_m1)
    );

    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        // Only the addressed column takes the load.
        assign col_load_we[c] = load_we && (load_col == 2'(c));

        vstream_column u_column (
            .clk       (clk),
            .rst       (rst),
            .load_we   (col_load_we[c]),
            .load_idx  (load_idx),
            .load_data (load_data),
            .len_m1    (len_m1[c]),
            .sel       (sel_mux2[c]),
            .data      (col_data[c]),
            .valid     (col_valid[c]),
            .done      (col_done[c])
        );
    end

    vstreamout_control u_control (
        .clk                  (clk),
        .rst                  (rst),
        .is_vstreamout        (is_vstreamout),
        .done                 (col_done),
        .rd_addr              (rd_addr),
        .supplier             (supplier),
        .streamout_addr       (streamout_addr),
        .is_vstreamout_global (busy),
        .sel_mux2             (sel_mux2)
    );

    vstream_regfile u_regfile (
        .clk            (clk),
        .rst            (rst),
        .col_data       (col_data),
        .col_valid      (col_valid),
        .sel_mux2       (sel_mux2),
        .streamout_addr (streamout_addr),
        .busy           (busy),
        .rf_rd_addr     (rf_rd_addr),
        .rf_rd_data     (rf_rd_data),
        .out_valid      (out_valid),
        .out_data       (out_data)
    );

endmodule

// File: tb/tb_vstream_unit.sv
`timescale 1ns/1ps

module tb_vstream_unit
    import vstream_pkg::*;
;

    // Cycle budget of each kind of step for the run limit.
    localparam int LOAD_CYC   = NUM_COL * VEC_LEN + 1;
    localparam int CFG_CYC    = 2 * NUM_COL;
    localparam int STREAM_CYC = NUM_COL * VEC_LEN + 3;
    localparam int TEST_CYC   = 2 + 2 * LOAD_CYC + 5 * CFG_CYC + 7 * STREAM_CYC + 20;
    localparam int MAX_CYCLES = 2 * (TEST_CYC + 16);

    logic                 clk;
    logic                 rst;
    logic                 load_we;
    logic [1:0]           load_col;
    logic [IDX_W-1:0]     load_idx;
    logic [DATA_W-1:0]    load_data;
    logic                 cfg_we;
    logic [1:0]           cfg_col;
    logic [IDX_W-1:0]     cfg_len_m1;
    logic [NUM_COL-1:0]   is_vstreamout;
    logic [RF_ADDR_W-1:0] rd_addr;
    logic [RF_ADDR_W-1:0] rf_rd_addr;
    logic                 busy;
    logic [NUM_COL-1:0]   supplier;
    logic                 out_valid;
    logic [DATA_W-1:0]    out_data;
    logic [DATA_W-1:0]    rf_rd_data;

    // Reference model state.
    logic [DATA_W-1:0] m_buf [NUM_COL][VEC_LEN];
    int                m_len [NUM_COL];
    logic [DATA_W-1:0] m_rf  [RF_DEPTH];

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          tests_run;
    int          cycle_cnt;
    int          test_err_start;

    vstream_unit DUT (
        .clk           (clk),
        .rst           (rst),
        .load_we       (load_we),
        .load_col      (load_col),
        .load_idx      (load_idx),
        .load_data     (load_data),
        .cfg_we        (cfg_we),
        .cfg_col       (cfg_col),
        .cfg_len_m1    (cfg_len_m1),
        .is_vstreamout (is_vstreamout),
        .rd_addr       (rd_addr),
        .rf_rd_addr    (rf_rd_addr),
        .busy          (busy),
        .supplier      (supplier),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .rf_rd_data    (rf_rd_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped: exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err_start);
        end
    endtask

    task automatic load_columns();
        logic [31:0] v;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                rand_bits(DATA_W, v);
                @(negedge clk);
                load_we   = 1'b1;
                load_col  = 2'(c);
                load_idx  = IDX_W'(i);
                load_data = v[DATA_W-1:0];
                m_buf[c][i] = v[DATA_W-1:0];
            end
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic write_config(input int c, input int len_m1);
        @(negedge clk);
        cfg_we     = 1'b1;
        cfg_col    = 2'(c);
        cfg_len_m1 = IDX_W'(len_m1);
        m_len[c]   = len_m1 + 1;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic random_config();
        logic [31:0] v;
        for (int c = 0; c < NUM_COL; c++) begin
            rand_bits(IDX_W, v);
            write_config(c, int'(v[IDX_W-1:0]));
        end
    endtask

    // Runs one stream and checks each word, its column and the busy length.
    task automatic run_stream(input int addr, input bit pulse_busy, input bit move_addr);
        logic [DATA_W-1:0] exp_words[$];
        int                exp_cols[$];
        logic [31:0]       v;
        int                k;
        int                total;
        bit                overrun;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int i = 0; i < m_len[c]; i++) begin
                exp_words.push_back(m_buf[c][i]);
                exp_cols.push_back(c);
            end
        end
        total   = exp_words.size();
        k       = 0;
        overrun = 1'b0;
        rand_bits(NUM_COL, v);
        @(negedge clk);
        is_vstreamout = (v[NUM_COL-1:0] == '0) ? NUM_COL'(1) : v[NUM_COL-1:0];
        rd_addr       = RF_ADDR_W'(addr);
        forever begin
            @(negedge clk);
            if (!busy) begin
                is_vstreamout = '0;
                break;
            end
            assert (k < total) else begin
                $display("Stream produced more words than the configured lengths allow");
                errors++;
                overrun = 1'b1;
            end
            if (overrun) begin
                is_vstreamout = '0;
                break;
            end
            check_val("out_valid", 32'(out_valid), 32'd1);
            check_val("out_data", 32'(out_data), 32'(exp_words[k]));
            check_val("supplier", 32'(supplier), 32'd1 << exp_cols[k]);
            m_rf[(addr + k) % RF_DEPTH] = exp_words[k];
            k++;
            is_vstreamout = '0;
            if (pulse_busy) begin
                rand_bits(NUM_COL, v);
                is_vstreamout = v[NUM_COL-1:0];
            end
            if (move_addr) begin
                rand_bits(RF_ADDR_W, v);
                rd_addr = v[RF_ADDR_W-1:0];
            end
        end
        check_val("busy_cycles", 32'(k), 32'(total));
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("supplier", 32'(supplier), 32'd1);
    endtask

    task automatic check_regfile();
        @(negedge clk);
        for (int a = 0; a < RF_DEPTH; a++) begin
            rf_rd_addr = RF_ADDR_W'(a);
            #0.1;
            check_val($sformatf("rf_rd_data[%0d]", a), 32'(rf_rd_data), 32'(m_rf[a]));
        end
    endtask

    initial begin
        logic [31:0] v;
        clk           = 1'b0;
        rst           = 1'b1;
        load_we       = 1'b0;
        load_col      = '0;
        load_idx      = '0;
        load_data     = '0;
        cfg_we        = 1'b0;
        cfg_col       = '0;
        cfg_len_m1    = '0;
        is_vstreamout = '0;
        rd_addr       = '0;
        rf_rd_addr    = '0;
        lfsr          = 16'd25688;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        cycle_cnt     = 0;
        for (int c = 0; c < NUM_COL; c++) begin
            m_len[c] = VEC_LEN;
            for (int i = 0; i < VEC_LEN; i++) begin
                m_buf[c][i] = '0;
            end
        end
        for (int a = 0; a < RF_DEPTH; a++) begin
            m_rf[a] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        start_test();
        @(negedge clk);
        check_val("busy", 32'(busy), 32'd0);
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("supplier", 32'(supplier), 32'd1);
        for (int n = 0; n < 8; n++) begin
            rand_bits(RF_ADDR_W, v);
            rf_rd_addr = v[RF_ADDR_W-1:0];
            #0.1;
            check_val("rf_rd_data", 32'(rf_rd_data), 32'd0);
        end
        end_test("reset");

        start_test();
        load_columns();
        rand_bits(RF_ADDR_W, v);
        run_stream(int'(v[RF_ADDR_W-1:0]), 1'b0, 1'b0);
        check_regfile();
        end_test("full_length");

        start_test();
        for (int r = 0; r < 3; r++) begin
            random_config();
            rand_bits(RF_ADDR_W, v);
            run_stream(int'(v[RF_ADDR_W-1:0]), 1'b0, 1'b0);
            check_regfile();
        end
        end_test("random_lengths");

        // A start just below the top must wrap the writes to address 0.
        start_test();
        for (int c = 0; c < NUM_COL; c++) begin
            write_config(c, VEC_LEN - 1);
        end
        rand_bits(2, v);
        run_stream(RF_DEPTH - 1 - int'(v[1:0]), 1'b0, 1'b1);
        check_regfile();
        end_test("wrap_capture");

        start_test();
        load_columns();
        random_config();
        rand_bits(RF_ADDR_W, v);
        run_stream(int'(v[RF_ADDR_W-1:0]), 1'b1, 1'b0);
        rand_bits(RF_ADDR_W, v);
        run_stream(int'(v[RF_ADDR_W-1:0]), 1'b0, 1'b0);
        check_regfile();
        end_test("busy_requests");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vstream_unit.f
verilog/vstream_pkg.sv
verilog/vstream_config.sv
verilog/vstream_column.sv
verilog/vstreamout_control.sv
verilog/vstream_regfile.sv
verilog/vstream_unit.sv
tb/tb_vstream_unit.sv

// File: Bender.yml
package:
  name: vstream_unit

sources:
  - verilog/vstream_pkg.sv
  - verilog/vstream_config.sv
  - verilog/vstream_column.sv
  - verilog/vstreamout_control.sv
  - verilog/vstream_regfile.sv
  - verilog/vstream_unit.sv
  - target: test
    files:
      - tb/tb_vstream_unit.sv
